/* src/audio_mixer_cfg.svh */
/*
 * Build-time constants for the stereo audio mixer.
 * Included by the package and by every module that needs a width,
 * the I2S frame layout or an APB register offset.
 */
`ifndef AUDIO_MIXER_CFG_SVH
`define AUDIO_MIXER_CFG_SVH

// Datapath widths
`define SAMPLE_W    16
`define COEF_W      16
`define COEF_FRAC   14

// I2S framing, sck period is 2*SCK_DIV ck cycles
`define SLOT_BITS   32
`define POSN_W      6
`define SCK_DIV     4
`define LANES       2

// APB register map
`define APB_ADDR_W  8
`define REG_CONTROL 8'h00
`define REG_STATUS  8'h04
`define REG_COEF0   8'h10
`define REG_COEF1   8'h14
`define REG_COEF2   8'h18
`define REG_COEF3   8'h1C
`define REG_OUT_L   8'h20
`define REG_OUT_R   8'h24

`endif

/* src/audio_mixer_pkg.sv */
/*
 * Shared types of the audio mixer: samples, coefficients,
 * frame position, APB address and the receiver FSM states.
 * Referenced with scoped names from the RTL.
 */
`include "audio_mixer_cfg.svh"

package audio_mixer_pkg;

    // Signed PCM sample
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // Signed gain, 1.0 is 1 << COEF_FRAC
    typedef logic signed [`COEF_W-1:0] coef_t;

    // Bit position within an I2S frame
    typedef logic [`POSN_W-1:0] posn_t;

    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;

    // Receiver FSM
    typedef enum logic [1:0] {
        rx_idle,
        rx_left,
        rx_right
    } rx_state_t;

endpackage

/* src/apb_mixer_regs.sv */
/*
 * APB slave of the mixer, zero wait states.
 * Holds control, the four gains, the sticky clip flag, the frame
 * count and the readback of the last mixed frame.
 */
`timescale 1ns/1ps
`include "audio_mixer_cfg.svh"

module apb_mixer_regs (
    input  logic                       ck,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  audio_mixer_pkg::apb_addr_t paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    output logic                       enable,
    output audio_mixer_pkg::coef_t     coef [2*`LANES],
    input  audio_mixer_pkg::sample_t   lane_result [`LANES],
    input  logic [`LANES-1:0]          lane_clip,
    input  logic                       frame_done
);

    audio_mixer_pkg::sample_t last_result [`LANES];
    logic       clip_flag;
    logic [7:0] frame_count;
    logic       wr_en;
    logic       rd_en;
    logic       clip_clr;

    // Access phase of a transfer
    assign wr_en = psel && penable && pwrite;
    assign rd_en = psel && penable && !pwrite;

    assign clip_clr = wr_en && (paddr == `REG_STATUS) && pwdata[0];

    always_ff @(posedge ck) begin
        if (rst) begin
            enable      <= 1'b0;
            clip_flag   <= 1'b0;
            frame_count <= 8'd0;
            for (int i = 0; i < 2*`LANES; i++) begin
                coef[i] <= '0;
            end
            for (int i = 0; i < `LANES; i++) begin
                last_result[i] <= '0;
            end
        end else begin
            if (wr_en) begin
                case (paddr)
                    `REG_CONTROL: enable  <= pwdata[0];
                    `REG_COEF0:   coef[0] <= pwdata[`COEF_W-1:0];
                    `REG_COEF1:   coef[1] <= pwdata[`COEF_W-1:0];
                    `REG_COEF2:   coef[2] <= pwdata[`COEF_W-1:0];
                    `REG_COEF3:   coef[3] <= pwdata[`COEF_W-1:0];
                    default: ;
                endcase
            end

            // A new clip in the same cycle beats the host clear
            clip_flag <= (clip_flag && !clip_clr) || (frame_done && |lane_clip);

            if (frame_done) begin
                frame_count <= frame_count + 8'd1;
                for (int i = 0; i < `LANES; i++) begin
                    last_result[i] <= lane_result[i];
                end
            end
        end
    end

    // Read mux, only driven in the access phase of a read
    always_comb begin
        prdata = 32'd0;
        if (rd_en) begin
            case (paddr)
                `REG_CONTROL: prdata = {31'd0, enable};
                `REG_STATUS:  prdata = {16'd0, frame_count, 7'd0, clip_flag};
                `REG_COEF0:   prdata = {{(32-`COEF_W){1'b0}}, coef[0]};
                `REG_COEF1:   prdata = {{(32-`COEF_W){1'b0}}, coef[1]};
                `REG_COEF2:   prdata = {{(32-`COEF_W){1'b0}}, coef[2]};
                `REG_COEF3:   prdata = {{(32-`COEF_W){1'b0}}, coef[3]};
                `REG_OUT_L: begin
                    prdata = {{(32-`SAMPLE_W){last_result[0][`SAMPLE_W-1]}},
                              last_result[0]};
                end
                `REG_OUT_R: begin
                    prdata = {{(32-`SAMPLE_W){last_result[1][`SAMPLE_W-1]}},
                              last_result[1]};
                end
                default:      prdata = 32'd0;
            endcase
        end
    end

endmodule

/* src/i2s_clock.sv */
/*
 * I2S timing generator running on ck.
 * Produces sck, ws, the bit position in the frame and
 * one-cycle strobes marking the ck edge where sck rises or falls.
 */
`timescale 1ns/1ps
`include "audio_mixer_cfg.svh"

module i2s_clock (
    input  logic                   ck,
    input  logic                   rst,
    output logic                   sck,
    output logic                   ws,
    output audio_mixer_pkg::posn_t posn,
    output logic                   sck_rise,
    output logic                   sck_fall
);

    localparam int DIV_W = $clog2(`SCK_DIV);
    localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(`SCK_DIV - 1);
    localparam audio_mixer_pkg::posn_t FRAME_LAST = `POSN_W'(2*`SLOT_BITS - 1);

    logic [DIV_W-1:0] div_cnt;
    logic             div_wrap;

    assign div_wrap = (div_cnt == DIV_LAST);

    // Strobes are high in the cycle before sck toggles
    assign sck_rise = div_wrap && !sck;
    assign sck_fall = div_wrap && sck;

    // Left slot in the lower half of the frame
    assign ws = posn[`POSN_W-1];

    always_ff @(posedge ck) begin
        if (rst) begin
            div_cnt <= '0;
            sck     <= 1'b0;
            posn    <= '0;
        end else begin
            div_cnt <= div_wrap ? '0 : div_cnt + 1'b1;
            if (div_wrap) begin
                sck <= !sck;
            end
            if (sck_fall) begin
                posn <= (posn == FRAME_LAST) ? '0 : posn + 1'b1;
            end
        end
    end

endmodule

/* src/i2s_rx.sv */
/*
 * I2S receiver. Samples sd_in on sck rising edges, collects the
 * left then the right sample and publishes both with a one-cycle
 * pair_valid after the last right bit.
 */
`timescale 1ns/1ps
`include "audio_mixer_cfg.svh"

module i2s_rx (
    input  logic                     ck,
    input  logic                     rst,
    input  logic                     sck_rise,
    input  audio_mixer_pkg::posn_t   posn,
    input  logic                     sd_in,
    output audio_mixer_pkg::sample_t in_left,
    output audio_mixer_pkg::sample_t in_right,
    output logic                     pair_valid
);

    localparam audio_mixer_pkg::posn_t LEFT_FIRST  = `POSN_W'(1);
    localparam audio_mixer_pkg::posn_t LEFT_LAST   = `POSN_W'(`SAMPLE_W);
    localparam audio_mixer_pkg::posn_t RIGHT_FIRST = `POSN_W'(`SLOT_BITS + 1);
    localparam audio_mixer_pkg::posn_t RIGHT_LAST  = `POSN_W'(`SLOT_BITS + `SAMPLE_W);

    audio_mixer_pkg::rx_state_t state;
    logic [2*`SAMPLE_W-1:0] shreg;
    logic [2*`SAMPLE_W-1:0] shift_next;
    logic                   shift_en;
    logic                   publish;

    assign shift_next = {shreg[2*`SAMPLE_W-2:0], sd_in};

    assign shift_en = sck_rise &&
        ((state == audio_mixer_pkg::rx_idle && posn == LEFT_FIRST) ||
         (state == audio_mixer_pkg::rx_left) ||
         (state == audio_mixer_pkg::rx_right && posn >= RIGHT_FIRST));

    assign publish = sck_rise && state == audio_mixer_pkg::rx_right && posn == RIGHT_LAST;

    always_ff @(posedge ck) begin
        if (rst) begin
            state      <= audio_mixer_pkg::rx_idle;
            pair_valid <= 1'b0;
        end else begin
            pair_valid <= publish;
            if (sck_rise) begin
                case (state)
                    audio_mixer_pkg::rx_idle:
                        if (posn == LEFT_FIRST) state <= audio_mixer_pkg::rx_left;
                    audio_mixer_pkg::rx_left:
                        if (posn == LEFT_LAST) state <= audio_mixer_pkg::rx_right;
                    audio_mixer_pkg::rx_right:
                        if (posn == RIGHT_LAST) state <= audio_mixer_pkg::rx_idle;
                    default: state <= audio_mixer_pkg::rx_idle;
                endcase
            end
        end
    end

    always_ff @(posedge ck) begin
        if (shift_en) begin
            shreg <= shift_next;
        end
        if (publish) begin
            in_left  <= shift_next[2*`SAMPLE_W-1:`SAMPLE_W];
            in_right <= shift_next[`SAMPLE_W-1:0];
        end
    end

endmodule

/* src/mix_lane.sv */
/*
 * One output channel: result = sat((left*coef_a + right*coef_b) >>> COEF_FRAC).
 * Three register stages, out_valid follows pair_valid by 3 ck cycles.
 * Instantiated once per output channel in the mixer top.
 */
`timescale 1ns/1ps
`include "audio_mixer_cfg.svh"

module mix_lane (
    input  logic                     ck,
    input  logic                     rst,
    input  logic                     enable,
    input  logic                     pair_valid,
    input  audio_mixer_pkg::sample_t in_left,
    input  audio_mixer_pkg::sample_t in_right,
    input  audio_mixer_pkg::coef_t   coef_a,
    input  audio_mixer_pkg::coef_t   coef_b,
    output audio_mixer_pkg::sample_t result,
    output logic                     clip,
    output logic                     out_valid
);

    localparam int PROD_W = `SAMPLE_W + `COEF_W;
    localparam int ACC_W  = PROD_W + 1;
    localparam logic signed [ACC_W-1:0] SAT_MAX = (ACC_W'(1) <<< (`SAMPLE_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] SAT_MIN = -(ACC_W'(1) <<< (`SAMPLE_W - 1));

    logic signed [PROD_W-1:0] prod_a;
    logic signed [PROD_W-1:0] prod_b;
    logic signed [ACC_W-1:0]  acc;
    logic                     valid_1;
    logic                     valid_2;

    // Stage valids
    always_ff @(posedge ck) begin
        if (rst) begin
            valid_1   <= 1'b0;
            valid_2   <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_1   <= pair_valid;
            valid_2   <= valid_1;
            out_valid <= valid_2;
        end
    end

    // Stage 1 and 2, products then scaled sum
    always_ff @(posedge ck) begin
        if (pair_valid) begin
            prod_a <= in_left * coef_a;
            prod_b <= in_right * coef_b;
        end
        if (valid_1) begin
            // Extended to ACC_W before the add, so the sum cannot wrap
            acc <= (prod_a + prod_b) >>> `COEF_FRAC;
        end
    end

    // Stage 3, clamp to the sample range
    always_ff @(posedge ck) begin
        if (rst) begin
            result <= '0;
            clip   <= 1'b0;
        end else if (valid_2) begin
            if (!enable) begin
                result <= '0;
                clip   <= 1'b0;
            end else if (acc > SAT_MAX) begin
                result <= {1'b0, {(`SAMPLE_W-1){1'b1}}};
                clip   <= 1'b1;
            end else if (acc < SAT_MIN) begin
                result <= {1'b1, {(`SAMPLE_W-1){1'b0}}};
                clip   <= 1'b1;
            end else begin
                result <= acc[`SAMPLE_W-1:0];
                clip   <= 1'b0;
            end
        end
    end

endmodule

/* src/i2s_tx.sv */
/*
 * I2S transmitter. Loads both channel results at the start of a
 * frame and shifts them out MSB first, one bit per sck falling edge.
 */
`timescale 1ns/1ps
`include "audio_mixer_cfg.svh"

module i2s_tx (
    input  logic                     ck,
    input  logic                     rst,
    input  logic                     sck_fall,
    input  audio_mixer_pkg::posn_t   posn,
    input  audio_mixer_pkg::sample_t out_left,
    input  audio_mixer_pkg::sample_t out_right,
    output logic                     sd_out
);

    localparam audio_mixer_pkg::posn_t FRAME_LAST = `POSN_W'(2*`SLOT_BITS - 1);

    logic [2*`SAMPLE_W-1:0]   shreg;
    audio_mixer_pkg::posn_t   posn_next;
    logic                     data_bit;

    // Position that the coming falling edge begins
    assign posn_next = (posn == FRAME_LAST) ? '0 : posn + 1'b1;

    assign data_bit = (posn_next >= 1 && posn_next <= `SAMPLE_W) ||
                      (posn_next >= `SLOT_BITS + 1 && posn_next <= `SLOT_BITS + `SAMPLE_W);

    always_ff @(posedge ck) begin
        if (rst) begin
            shreg  <= '0;
            sd_out <= 1'b0;
        end else if (sck_fall) begin
            if (posn_next == '0) begin
                shreg  <= {out_left, out_right};
                sd_out <= 1'b0;
            end else if (data_bit) begin
                sd_out <= shreg[2*`SAMPLE_W-1];
                shreg  <= {shreg[2*`SAMPLE_W-2:0], 1'b0};
            end else begin
                // Padding bits of each slot
                sd_out <= 1'b0;
            end
        end
    end

endmodule

/* src/audio_mixer.sv */
/*
 * Stereo audio mixer top level.
 * APB host access to gains and status, I2S in and out on pins,
 * one mixing lane per output channel between receiver and transmitter.
 */
`timescale 1ns/1ps
`include "audio_mixer_cfg.svh"

module audio_mixer (
    input  logic                       ck,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  audio_mixer_pkg::apb_addr_t paddr,
    input  logic [31:0]                pwdata,
    output logic [31:0]                prdata,
    input  logic                       sd_in,
    output logic                       sck,
    output logic                       ws,
    output logic                       sd_out
);

    logic                     sck_rise;
    logic                     sck_fall;
    audio_mixer_pkg::posn_t   posn;
    audio_mixer_pkg::sample_t in_left;
    audio_mixer_pkg::sample_t in_right;
    logic                     pair_valid;
    logic                     enable;
    audio_mixer_pkg::coef_t   coef [2*`LANES];
    audio_mixer_pkg::sample_t lane_result [`LANES];
    logic [`LANES-1:0]        lane_clip;
    logic [`LANES-1:0]        lane_valid;

    i2s_clock u_clock (
        .ck       (ck),
        .rst      (rst),
        .sck      (sck),
        .ws       (ws),
        .posn     (posn),
        .sck_rise (sck_rise),
        .sck_fall (sck_fall)
    );

    i2s_rx u_rx (
        .ck         (ck),
        .rst        (rst),
        .sck_rise   (sck_rise),
        .posn       (posn),
        .sd_in      (sd_in),
        .in_left    (in_left),
        .in_right   (in_right),
        .pair_valid (pair_valid)
    );

    // Lane i mixes with coefficients 2i and 2i+1
    for (genvar i = 0; i < `LANES; i++) begin : g_lane
        mix_lane u_lane (
            .ck         (ck),
            .rst        (rst),
            .enable     (enable),
            .pair_valid (pair_valid),
            .in_left    (in_left),
            .in_right   (in_right),
            .coef_a     (coef[2*i]),
            .coef_b     (coef[2*i+1]),
            .result     (lane_result[i]),
            .clip       (lane_clip[i]),
            .out_valid  (lane_valid[i])
        );
    end

    // Frame done is the out_valid of lane 0
    apb_mixer_regs u_regs (
        .ck          (ck),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .enable      (enable),
        .coef        (coef),
        .lane_result (lane_result),
        .lane_clip   (lane_clip),
        .frame_done  (lane_valid[0])
    );

    i2s_tx u_tx (
        .ck        (ck),
        .rst       (rst),
        .sck_fall  (sck_fall),
        .posn      (posn),
        .out_left  (lane_result[0]),
        .out_right (lane_result[1]),
        .sd_out    (sd_out)
    );

endmodule

/* tb/audio_mixer_checker.sv */
/*
 * Concurrent assertions on the mixer's APB port, I2S framing and
 * reset state. Bound into audio_mixer from the testbench build.
 */
`timescale 1ns/1ps

module audio_mixer_checker (
    input logic ck,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic sck,
    input logic ws,
    input logic sd_out,
    input logic pair_valid
);

    // Access phase must follow a setup cycle
    apb_setup_first: assert property (@(posedge ck) disable iff (rst)
        (penable && !$past(penable)) |-> ($past(psel) && psel))
        else $error("APB access phase without a setup cycle");

    // Word select moves together with the falling sck
    ws_on_sck_fall: assert property (@(posedge ck) disable iff (rst)
        $changed(ws) |-> $fell(sck))
        else $error("ws changed away from a falling sck edge");

    pair_valid_single: assert property (@(posedge ck) disable iff (rst)
        pair_valid |=> !pair_valid)
        else $error("pair_valid high on two consecutive cycles");

    reset_quiet: assert property (@(posedge ck)
        (rst && $past(rst)) |-> (!sd_out && !sck && !pair_valid))
        else $error("I2S outputs active during reset");

endmodule

bind audio_mixer audio_mixer_checker u_checker (
    .ck         (ck),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .sck        (sck),
    .ws         (ws),
    .sd_out     (sd_out),
    .pair_valid (pair_valid)
);

/* tb/audio_mixer_tb.sv */
/*
 * Testbench of the audio mixer. Drives APB and an I2S source,
 * decodes the I2S output and compares every frame with a model
 * of the mixing rule. Random stimulus comes from an xorshift generator.
 */
`timescale 1ns/1ps
`include "audio_mixer_cfg.svh"

module audio_mixer_tb;

    localparam int  TOTAL_FRAMES  = 80;
    localparam real TIMEOUT_NS    = 1.5 * TOTAL_FRAMES * 4096.0;
    localparam int  CK_PERIOD_NS  = 8;
    localparam int  SCK_PERIOD_NS = 2 * `SCK_DIV * CK_PERIOD_NS;

    logic        ck;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic        sd_in;
    logic        sck;
    logic        ws;
    logic        sd_out;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;

    logic [31:0]        rng;
    logic [5:0]         cnt;
    logic signed [15:0] cur_l;
    logic signed [15:0] cur_r;
    logic signed [15:0] coef_m [4];
    bit                 en_m;
    bit                 clip_sticky;
    bit                 full_scale;
    logic [7:0]         frame_cnt_m;
    logic [31:0]        exp_q [$];
    logic [31:0]        last_exp;
    int                 frames_seen;

    audio_mixer UUT (
        .ck(ck), .rst(rst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .prdata(prdata),
        .sd_in(sd_in), .sck(sck), .ws(ws), .sd_out(sd_out)
    );

    always #(CK_PERIOD_NS / 2) ck = ~ck;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Saturated weighted sum with the clip flag in bit 16
    function automatic logic [16:0] mix_model(input logic signed [15:0] l, r, a, b,
                                              input bit en);
        longint acc;
        acc = (longint'(l) * longint'(a) + longint'(r) * longint'(b)) >>> 14;
        if (!en) return 17'd0;
        if (acc > 32767) return {1'b1, 16'h7fff};
        if (acc < -32768) return {1'b1, 16'h8000};
        return {1'b0, acc[15:0]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, got);
        assert (exp === got) else begin
            $display("** Error %s: expected %h, actual %h", name, exp, got);
            $display("CHECKS FAILED");
            $fatal(1);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge ck);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge ck);
        penable <= 1'b1;
        @(posedge ck);
        psel    <= 1'b0;
        penable <= 1'b0;
        // Mirror the register in the model
        if (addr == `REG_CONTROL) en_m = data[0];
        if (addr == `REG_STATUS && data[0]) clip_sticky = 1'b0;
        if (addr >= `REG_COEF0 && addr <= `REG_COEF3) coef_m[(addr - 8'h10) >> 2] = data[15:0];
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge ck);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge ck);
        penable <= 1'b1;
        @(negedge ck);
        data = prdata;
        @(posedge ck);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    // Wait for the early part of the left slot
    task automatic wait_window();
        @(posedge ck);
        while (!(cnt >= 2 && cnt <= 20)) @(posedge ck);
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = frames_seen + n;
        while (frames_seen < target) @(posedge ck);
    endtask

    task automatic write_coefs(input logic [15:0] c0, c1, c2, c3);
        wait_window();
        apb_write(`REG_COEF0, {16'd0, c0});
        apb_write(`REG_COEF1, {16'd0, c1});
        apb_write(`REG_COEF2, {16'd0, c2});
        apb_write(`REG_COEF3, {16'd0, c3});
    endtask

    // I2S source drives one bit per sck period after the falling edge
    initial begin : i2s_source
        logic [5:0]  next;
        logic [16:0] ml, mr;
        time         last_fall;
        last_fall = 0;
        wait (!rst);
        forever begin
            @(negedge sck);
            if (last_fall != 0) begin
                check_value("sck period", 32'(SCK_PERIOD_NS), 32'($time - last_fall));
            end
            last_fall = $time;
            @(posedge ck);
            next = cnt + 6'd1;
            cnt <= next;
            check_value("ws", {31'd0, next[5]}, {31'd0, ws});
            if (next == 6'd1) begin
                rng = xorshift(rng);
                if (full_scale) begin
                    cur_l = rng[0] ? 16'sh7fff : 16'sh8000;
                    cur_r = rng[1] ? 16'sh7fff : 16'sh8000;
                end else begin
                    cur_l = rng[15:0];
                    cur_r = rng[31:16];
                end
            end
            if (next >= 1 && next <= 16) sd_in <= cur_l[16 - int'(next)];
            else if (next >= 33 && next <= 48) sd_in <= cur_r[48 - int'(next)];
            else sd_in <= 1'b0;
            if (next == 6'd50) begin
                ml = mix_model(cur_l, cur_r, coef_m[0], coef_m[1], en_m);
                mr = mix_model(cur_l, cur_r, coef_m[2], coef_m[3], en_m);
                if (ml[16] || mr[16]) clip_sticky = 1'b1;
                frame_cnt_m = frame_cnt_m + 8'd1;
                last_exp = {ml[15:0], mr[15:0]};
                exp_q.push_back(last_exp);
            end
        end
    end

    // I2S sink samples sd_out on rising sck
    initial begin : i2s_sink
        logic [15:0] sl, sr;
        logic [31:0] exp;
        wait (!rst);
        forever begin
            @(posedge sck);
            if (cnt >= 1 && cnt <= 16) sl = {sl[14:0], sd_out};
            if (cnt >= 33 && cnt <= 48) sr = {sr[14:0], sd_out};
            if (cnt == 6'd48) begin
                exp = (exp_q.size() > 0) ? exp_q.pop_front() : 32'd0;
                check_value("frame left", {16'd0, exp[31:16]}, {16'd0, sl});
                check_value("frame right", {16'd0, exp[15:0]}, {16'd0, sr});
                frames_seen++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the I2S stream stopped or the tests ran too long");
        $display("CHECKS FAILED");
        $fatal(1);
    end

    initial begin : main
        logic [31:0] rd, s1, s2;
        logic [15:0] c [4];
        ck          = 1'b0;
        rst         = 1'b1;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        sd_in       = 1'b0;
        rng         = 32'h9617f182;
        cnt         = '0;
        cur_l       = '0;
        cur_r       = '0;
        en_m        = 0;
        clip_sticky = 0;
        full_scale  = 0;
        frame_cnt_m = '0;
        frames_seen = 0;
        for (int i = 0; i < 4; i++) coef_m[i] = '0;
        repeat (8) @(posedge ck);
        rst <= 1'b0;

        // Register access
        for (int i = 0; i < 4; i++) begin
            rng = xorshift(rng);
            c[i] = rng[15:0];
        end
        write_coefs(c[0], c[1], c[2], c[3]);
        for (int i = 0; i < 4; i++) begin
            apb_read(8'h10 + 8'(4 * i), rd);
            check_value("register readback", {16'd0, c[i]}, rd);
        end
        wait_window();
        apb_write(`REG_CONTROL, 32'd1);
        apb_read(`REG_CONTROL, rd);
        check_value("control readback", 32'd1, rd);

        // Pass-through and swapped channels
        write_coefs(16'd16384, 16'd0, 16'd0, 16'd16384);
        wait_frames(6);
        write_coefs(16'd0, 16'd16384, 16'd16384, 16'd0);
        wait_frames(6);

        // Random gains on random input
        for (int k = 0; k < 3; k++) begin
            rng = xorshift(rng);
            s1 = xorshift(rng);
            write_coefs(rng[15:0], rng[31:16], s1[15:0], s1[31:16]);
            wait_frames(10);
        end
        wait_window();
        apb_read(`REG_OUT_L, rd);
        check_value("out_l readback", {{16{last_exp[31]}}, last_exp[31:16]}, rd);
        apb_read(`REG_OUT_R, rd);
        check_value("out_r readback", {{16{last_exp[15]}}, last_exp[15:0]}, rd);

        // Saturation and the sticky clip flag
        full_scale = 1;
        write_coefs(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff);
        wait_frames(8);
        write_coefs(16'd0, 16'd0, 16'd0, 16'd0);
        wait_frames(3);
        wait_window();
        check_value("clip occurred", 32'd1, {31'd0, clip_sticky});
        apb_read(`REG_STATUS, rd);
        check_value("status clip set", 32'd1, {31'd0, rd[0]});
        apb_write(`REG_STATUS, 32'd1);
        apb_read(`REG_STATUS, rd);
        check_value("status clip cleared", 32'd0, {31'd0, rd[0]});
        full_scale = 0;

        // Disabled output and frame count
        write_coefs(16'd16384, 16'd0, 16'd0, 16'd16384);
        apb_write(`REG_CONTROL, 32'd0);
        wait_frames(3);
        wait_window();
        apb_read(`REG_STATUS, s1);
        check_value("frame count", {24'd0, frame_cnt_m}, {24'd0, s1[15:8]});
        wait_frames(5);
        wait_window();
        apb_read(`REG_STATUS, s2);
        check_value("frame count delta", 32'd5, {24'd0, s2[15:8] - s1[15:8]});
        check_value("clip stays low", 32'd0, {31'd0, s2[0]});

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* audio_mixer.f */
+incdir+src
src/audio_mixer_pkg.sv
src/apb_mixer_regs.sv
src/i2s_clock.sv
src/i2s_rx.sv
src/mix_lane.sv
src/i2s_tx.sv
src/audio_mixer.sv
tb/audio_mixer_checker.sv
tb/audio_mixer_tb.sv

/* Makefile */
# Verilator build and run of the audio mixer testbench

VERILATOR ?= verilator
TOP       ?= audio_mixer_tb
FILELIST  ?= audio_mixer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: help test clean build

help:
	@echo "Targets:"
	@echo "  test   build and run the simulation, fails unless all checks pass"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
